// ==== logic/fsrc_settings.svh ====
// Build-time settings of the transmit sample-rate converter
//   Channel count, sample and accumulator widths
//   Wishbone byte address width
//   Identification constants returned by VERSION and MAGIC

`ifndef FSRC_SETTINGS_SVH
`define FSRC_SETTINGS_SVH

`define FSRC_NUM_CHANNELS 4
`define FSRC_SAMPLE_WIDTH 16

// Kept at 32 bits so that one preset fits one register
`define FSRC_ACCUM_WIDTH 32

`define FSRC_WB_ADDR_WIDTH 8

`define FSRC_CORE_VERSION 32'h00000100
`define FSRC_CORE_MAGIC 32'h46535243

`endif

// ==== logic/fsrc_pkg.sv ====
// Shared types of the transmit sample-rate converter
//   Sample and per-beat sample vector
//   Phase accumulator, preset array and channel mask

`default_nettype none

`include "fsrc_settings.svh"

package fsrc_pkg;

  typedef logic [`FSRC_SAMPLE_WIDTH-1:0] sample_t;

  // All channels of one beat, channel 0 in the low bits
  typedef sample_t [`FSRC_NUM_CHANNELS-1:0] sample_vec_t;

  typedef logic [`FSRC_ACCUM_WIDTH-1:0] accum_t;

  typedef accum_t [`FSRC_NUM_CHANNELS-1:0] accum_vec_t;

  // One bit per channel
  typedef logic [`FSRC_NUM_CHANNELS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// ==== logic/fsrc_valid_stage.sv ====
// Single pipeline stage with a valid flag and a typed payload
//   The flag is cleared by reset or flush
//   The payload only loads on a valid beat

`default_nettype none

module fsrc_valid_stage #(
  parameter type payload_t = logic
) (
  input  wire      clk,
  input  wire      arst_n,
  input  wire      flush,
  input  wire      in_valid,
  input  payload_t in_payload,
  output logic     out_valid,
  output payload_t out_payload
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Idle cycles leave the data path untouched
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_payload <= in_payload;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fsrc_phase_accum.sv ====
// Phase accumulator of one channel
//   Preset load, increment on each step
//   Combinational carry of the pending add

`default_nettype none

module fsrc_phase_accum
  import fsrc_pkg::*;
(
  input  wire    clk,
  input  wire    arst_n,
  input  wire    load,
  input  accum_t set_val,
  input  wire    step,
  input  accum_t add_val,
  output logic   carry
);

  localparam int unsigned AW = $bits(accum_t);

  accum_t        phase;
  logic [AW:0]   sum;

  // One extra bit catches the wrap of the add
  assign sum   = {1'b0, phase} + {1'b0, add_val};
  assign carry = sum[AW];

  // A preset load wins over a step in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= '0;
    end else if (load) begin
      phase <= set_val;
    end else if (step) begin
      phase <= sum[AW-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== logic/fsrc_rate_core.sv ====
// Sample path of the transmit sample-rate converter
//   Run state and beat acceptance
//   One phase accumulator per channel
//   Hole detection and the two-stage sample pipeline

`default_nettype none

`include "fsrc_settings.svh"

module fsrc_rate_core
  import fsrc_pkg::*;
(
  input  wire         clk,
  input  wire         arst_n,

  input  wire         enable,
  input  wire         run_start,
  input  wire         run_stop,
  input  wire         accum_set,
  input  accum_vec_t  set_vals,
  input  accum_t      add_val,
  input  chan_mask_t  conv_mask,

  input  wire         in_valid,
  input  sample_vec_t in_data,

  output logic        running,
  output logic        out_valid,
  output sample_vec_t out_data
);

  logic        accept;
  chan_mask_t  carry;
  chan_mask_t  hole;
  logic        s1_valid;
  sample_vec_t s1_data;
  chan_mask_t  s1_hole;
  sample_vec_t fill_data;

  // ************************************************************************
  // Run state
  // ************************************************************************

  // Stop and a dropped enable take priority over a start
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running <= 1'b0;
    end else if (!enable || run_stop) begin
      running <= 1'b0;
    end else if (run_start) begin
      running <= 1'b1;
    end
  end

  assign accept = in_valid & running;

  // ************************************************************************
  // Accumulator bank
  // ************************************************************************

  for (genvar i = 0; i < `FSRC_NUM_CHANNELS; i++) begin : g_chan
    fsrc_phase_accum accum_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .load    (accum_set),
      .set_val (set_vals[i]),
      .step    (accept),
      .add_val (add_val),
      .carry   (carry[i])
    );
  end

  // A channel gets a hole when it is converted and its phase wraps
  assign hole = carry & conv_mask;

  // ************************************************************************
  // Sample pipeline
  // ************************************************************************

  fsrc_valid_stage #(
    .payload_t (sample_vec_t)
  ) data_stage_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (1'b0),
    .in_valid    (accept),
    .in_payload  (in_data),
    .out_valid   (s1_valid),
    .out_payload (s1_data)
  );

  // Runs in lock step with the data stage, so its flag is not needed
  fsrc_valid_stage #(
    .payload_t (chan_mask_t)
  ) hole_stage_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (1'b0),
    .in_valid    (accept),
    .in_payload  (hole),
    .out_valid   (),
    .out_payload (s1_hole)
  );

  always_comb begin
    for (int i = 0; i < `FSRC_NUM_CHANNELS; i++) begin
      fill_data[i] = s1_hole[i] ? '0 : s1_data[i];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_data <= fill_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fsrc_wb_regmap.sv ====
// Register map of the transmit sample-rate converter
//   Wishbone classic slave with single-cycle acknowledge
//   Control, mask, increment and preset registers
//   Start, stop and accumulator-load command pulses
//   External start qualified by the trigger enable

`default_nettype none

`include "fsrc_settings.svh"

module fsrc_wb_regmap
  import fsrc_pkg::*;
(
  input  wire                           clk,
  input  wire                           arst_n,

  input  wire                           wb_cyc,
  input  wire                           wb_stb,
  input  wire                           wb_we,
  input  wire [`FSRC_WB_ADDR_WIDTH-1:0] wb_adr,
  input  wire [31:0]                    wb_dat_w,
  output logic                          wb_ack,
  output logic [31:0]                   wb_dat_r,

  input  wire                           ext_start,
  input  wire                           running,

  output logic                          enable,
  output logic                          run_start,
  output logic                          run_stop,
  output logic                          accum_set,
  output chan_mask_t                    conv_mask,
  output accum_t                        add_val,
  output accum_vec_t                    set_vals
);

  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_VERSION   = 'h00;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_MAGIC     = 'h04;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_CTRL      = 'h08;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_CMD       = 'h0C;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_CONV_MASK = 'h10;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_ADD_VAL   = 'h14;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_STATUS    = 'h18;
  localparam logic [`FSRC_WB_ADDR_WIDTH-1:0] ADR_SET_VAL   = 'h20;

  logic        wb_req;
  logic        wr_en;
  logic        cmd_wr;
  logic        ext_trig_en;
  logic        cmd_start;
  logic [31:0] rd_data;

  // ************************************************************************
  // Bus handshake
  // ************************************************************************

  // A request is served once, the ack drops again on the following edge
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wr_en  = wb_req & wb_we;
  assign cmd_wr = wr_en && (wb_adr == ADR_CMD);

  always_comb begin
    rd_data = '0;
    case (wb_adr)
      ADR_VERSION:   rd_data = `FSRC_CORE_VERSION;
      ADR_MAGIC:     rd_data = `FSRC_CORE_MAGIC;
      ADR_CTRL:      rd_data = {30'd0, ext_trig_en, enable};
      ADR_CONV_MASK: rd_data = 32'(conv_mask);
      ADR_ADD_VAL:   rd_data = add_val;
      ADR_STATUS:    rd_data = {31'd0, running};
      default:       rd_data = '0;
    endcase
    for (int i = 0; i < `FSRC_NUM_CHANNELS; i++) begin
      if (wb_adr == ADR_SET_VAL + 4 * i) begin
        rd_data = set_vals[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

  // ************************************************************************
  // Configuration and commands
  // ************************************************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack      <= 1'b0;
      enable      <= 1'b0;
      ext_trig_en <= 1'b0;
      conv_mask   <= '0;
      add_val     <= '0;
      set_vals    <= '0;
      cmd_start   <= 1'b0;
      run_stop    <= 1'b0;
      accum_set   <= 1'b0;
    end else begin
      wb_ack    <= wb_req;
      cmd_start <= cmd_wr & wb_dat_w[0];
      run_stop  <= cmd_wr & wb_dat_w[1];
      accum_set <= cmd_wr & wb_dat_w[2];
      if (wr_en) begin
        case (wb_adr)
          ADR_CTRL: begin
            enable      <= wb_dat_w[0];
            ext_trig_en <= wb_dat_w[1];
          end
          ADR_CONV_MASK: conv_mask <= wb_dat_w[`FSRC_NUM_CHANNELS-1:0];
          ADR_ADD_VAL:   add_val   <= wb_dat_w;
          default: ;
        endcase
        for (int i = 0; i < `FSRC_NUM_CHANNELS; i++) begin
          if (wb_adr == ADR_SET_VAL + 4 * i) begin
            set_vals[i] <= wb_dat_w;
          end
        end
      end
    end
  end

  // The external start acts in every cycle it is high while armed
  assign run_start = cmd_start | (ext_start & ext_trig_en);

endmodule

`default_nettype wire

// ==== logic/fsrc_tx_top.sv ====
// Top level of the transmit sample-rate converter
//   Wishbone register map
//   Rate core with the sample pipeline

`default_nettype none

`include "fsrc_settings.svh"

module fsrc_tx_top
  import fsrc_pkg::*;
(
  input  wire                           clk,
  input  wire                           arst_n,

  input  wire                           wb_cyc,
  input  wire                           wb_stb,
  input  wire                           wb_we,
  input  wire [`FSRC_WB_ADDR_WIDTH-1:0] wb_adr,
  input  wire [31:0]                    wb_dat_w,
  output wire                           wb_ack,
  output wire [31:0]                    wb_dat_r,

  input  wire                           ext_start,

  input  wire                           in_valid,
  input  sample_vec_t                   in_data,
  output wire                           out_valid,
  output sample_vec_t                   out_data
);

  wire        enable;
  wire        run_start;
  wire        run_stop;
  wire        accum_set;
  wire        running;
  chan_mask_t conv_mask;
  accum_t     add_val;
  accum_vec_t set_vals;

  fsrc_wb_regmap regmap_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .ext_start (ext_start),
    .running   (running),
    .enable    (enable),
    .run_start (run_start),
    .run_stop  (run_stop),
    .accum_set (accum_set),
    .conv_mask (conv_mask),
    .add_val   (add_val),
    .set_vals  (set_vals)
  );

  fsrc_rate_core rate_core_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .enable    (enable),
    .run_start (run_start),
    .run_stop  (run_stop),
    .accum_set (accum_set),
    .set_vals  (set_vals),
    .add_val   (add_val),
    .conv_mask (conv_mask),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .running   (running),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// ==== verif/fsrc_tx_checker.sv ====
// Concurrent assertions bound into the converter top level
//   Wishbone acknowledge shape
//   Two-cycle latency from accepted beat to output
//   Quiet output while the run is stopped

`default_nettype none

module fsrc_tx_checker (
  input wire clk,
  input wire arst_n,
  input wire wb_cyc,
  input wire wb_stb,
  input wire wb_ack,
  input wire in_valid,
  input wire running,
  input wire out_valid
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  ack_single: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held high for more than one cycle");
      fail_count++;
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> wb_cyc && wb_stb)
    else begin
      $error("wb_ack raised outside a bus cycle");
      fail_count++;
    end

  // A beat accepted at one edge is sampled on out_valid two edges later
  out_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid == $past(in_valid && running, 2))
    else begin
      $error("out_valid does not follow the accepted beats by two cycles");
      fail_count++;
    end

  quiet_when_stopped: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(running, 1) && !$past(running, 2) |-> !out_valid)
    else begin
      $error("out_valid high although the run is stopped");
      fail_count++;
    end

endmodule

bind fsrc_tx_top fsrc_tx_checker checker_inst (
  .clk       (clk),
  .arst_n    (arst_n),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .in_valid  (in_valid),
  .running   (running),
  .out_valid (out_valid)
);

`default_nettype wire

// ==== verif/fsrc_tx_tb.sv ====
// Testbench of the transmit sample-rate converter
//   Wishbone host tasks and a register model
//   Random sample stimulus with a reference model of the hole rule
//   Output monitor, watchdog and final report

`default_nettype none

`include "fsrc_settings.svh"

module fsrc_tx_tb
  import fsrc_pkg::*;
();

  localparam int NCH           = `FSRC_NUM_CHANNELS;
  localparam int AW            = `FSRC_WB_ADDR_WIDTH;
  localparam int CLK_PERIOD    = 8;
  localparam int TOTAL_BEATS   = 320;
  localparam int REG_ACCESSES  = 80;
  localparam int WATCHDOG_TIME = (TOTAL_BEATS + REG_ACCESSES) * CLK_PERIOD * 20;

  localparam logic [AW-1:0] ADR_VERSION   = 'h00;
  localparam logic [AW-1:0] ADR_MAGIC     = 'h04;
  localparam logic [AW-1:0] ADR_CTRL      = 'h08;
  localparam logic [AW-1:0] ADR_CMD       = 'h0C;
  localparam logic [AW-1:0] ADR_CONV_MASK = 'h10;
  localparam logic [AW-1:0] ADR_ADD_VAL   = 'h14;
  localparam logic [AW-1:0] ADR_STATUS    = 'h18;
  localparam logic [AW-1:0] ADR_SET_VAL   = 'h20;

  localparam logic [31:0] CMD_START     = 32'h1;
  localparam logic [31:0] CMD_STOP      = 32'h2;
  localparam logic [31:0] CMD_ACCUM_SET = 32'h4;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [AW-1:0] wb_adr;
  logic [31:0] wb_dat_w;
  wire         wb_ack;
  wire  [31:0] wb_dat_r;
  logic        ext_start;
  logic        in_valid;
  sample_vec_t in_data;
  wire         out_valid;
  sample_vec_t out_data;

  integer seed = 32'h5e89166a;
  int     cycle = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     err_mark = 0;

  // Reference model state
  logic [1:0] m_ctrl = '0;
  logic       m_run = 1'b0;
  chan_mask_t m_mask = '0;
  accum_t     m_add = '0;
  accum_vec_t m_set = '0;
  accum_vec_t m_acc = '0;
  sample_vec_t exp_q[$];
  int          due_q[$];

  fsrc_tx_top fsrc_tx_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .ext_start (ext_start),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ************************************************************************
  // Compare tasks
  // ************************************************************************

  task automatic reg_compare(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic beat_compare(input logic got_valid, input logic exp_valid,
                              input sample_vec_t got, input sample_vec_t exp);
    checks++;
    if (got_valid !== exp_valid) begin
      errors++;
      $display("MISMATCH t=%0t out_valid exp=%b got=%b", $time, exp_valid, got_valid);
    end else if (exp_valid && got !== exp) begin
      errors++;
      $display("MISMATCH t=%0t out_data exp=%h got=%h", $time, exp, got);
    end
  endtask

  // ************************************************************************
  // Register model and bus access
  // ************************************************************************

  function automatic int set_index(input logic [AW-1:0] adr);
    if (adr[1:0] == 2'b00 && adr >= ADR_SET_VAL && adr < ADR_SET_VAL + 4 * NCH) begin
      return (adr - ADR_SET_VAL) / 4;
    end
    return -1;
  endfunction

  function automatic logic [31:0] expected_read(input logic [AW-1:0] adr);
    logic [31:0] val;
    case (adr)
      ADR_VERSION:   val = `FSRC_CORE_VERSION;
      ADR_MAGIC:     val = `FSRC_CORE_MAGIC;
      ADR_CTRL:      val = 32'(m_ctrl);
      ADR_CONV_MASK: val = 32'(m_mask);
      ADR_ADD_VAL:   val = m_add;
      ADR_STATUS:    val = 32'(m_run);
      default:       val = '0;
    endcase
    if (set_index(adr) >= 0) begin
      val = m_set[set_index(adr)];
    end
    return val;
  endfunction

  // Stop and a dropped enable win over a start in the same write
  task automatic update_model(input logic [AW-1:0] adr, input logic [31:0] dat);
    case (adr)
      ADR_CTRL: begin
        m_ctrl = dat[1:0];
        if (!dat[0]) begin
          m_run = 1'b0;
        end
      end
      ADR_CMD: begin
        if (dat[1]) begin
          m_run = 1'b0;
        end else if (dat[0] && m_ctrl[0]) begin
          m_run = 1'b1;
        end
        if (dat[2]) begin
          m_acc = m_set;
        end
      end
      ADR_CONV_MASK: m_mask = dat[NCH-1:0];
      ADR_ADD_VAL:   m_add = dat;
      default: begin
        if (set_index(adr) >= 0) begin
          m_set[set_index(adr)] = dat;
        end
      end
    endcase
  endtask

  task automatic bus_cycle(input logic we, input logic [AW-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int wait_cnt;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    wait_cnt = 0;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (!wb_ack && wait_cnt < 16);
    if (!wb_ack) begin
      errors++;
      $display("ERROR: no acknowledge for the bus access at address %h", adr);
    end
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [AW-1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
    update_model(adr, dat);
  endtask

  task automatic read_check(input logic [AW-1:0] adr, input string name);
    logic [31:0] rdat;
    bus_cycle(1'b0, adr, '0, rdat);
    reg_compare(name, rdat, expected_read(adr));
  endtask

  // ************************************************************************
  // Sample stream and hole model
  // ************************************************************************

  // Every accepted beat steps all accumulators, masked wraps become zero
  task automatic queue_expected_beat(input sample_vec_t data, input int due);
    sample_vec_t exp;
    accum_t      next;
    exp = data;
    for (int i = 0; i < NCH; i++) begin
      next = m_acc[i] + m_add;
      // A wrapped sum ends up below the value it started from
      if (next < m_acc[i] && m_mask[i]) begin
        exp[i] = '0;
      end
      m_acc[i] = next;
    end
    exp_q.push_back(exp);
    due_q.push_back(due);
  endtask

  function automatic sample_vec_t random_beat();
    sample_vec_t beat;
    for (int i = 0; i < NCH; i++) begin
      beat[i] = sample_t'($random(seed));
    end
    return beat;
  endfunction

  // Accepted at the next edge, sampled on the third falling edge from now
  task automatic drive_beat(input logic valid, input sample_vec_t data);
    @(posedge clk);
    in_valid <= valid;
    in_data  <= data;
    if (valid && m_run) begin
      queue_expected_beat(data, cycle + 3);
    end
  endtask

  task automatic wait_drain();
    while (due_q.size() > 0) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic stream(input int beats, input int gap_pct);
    logic valid;
    for (int n = 0; n < beats; n++) begin
      valid = ($unsigned($random(seed)) % 100) >= gap_pct;
      drive_beat(valid, random_beat());
    end
    drive_beat(1'b0, '0);
    wait_drain();
  endtask

  task automatic pulse_ext_start();
    @(posedge clk);
    ext_start <= 1'b1;
    if (m_ctrl[1] && m_ctrl[0]) begin
      m_run = 1'b1;
    end
    @(posedge clk);
    ext_start <= 1'b0;
  endtask

  always @(negedge clk) begin
    cycle++;
    if (arst_n) begin
      if (due_q.size() > 0 && due_q[0] == cycle) begin
        beat_compare(out_valid, 1'b1, out_data, exp_q[0]);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        beat_compare(out_valid, 1'b0, out_data, '0);
      end
    end
  end

  // ************************************************************************
  // Tests
  // ************************************************************************

  task automatic test_done(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("[%0t] test %s: ok", $time, name);
    end else begin
      $display("[%0t] test %s: %0d errors", $time, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic registers_readback();
    logic [AW-1:0] adr;
    read_check(ADR_VERSION, "VERSION");
    read_check(ADR_MAGIC, "MAGIC");
    repeat (2) begin
      write_reg(ADR_CTRL, $random(seed));
      write_reg(ADR_CONV_MASK, $random(seed));
      write_reg(ADR_ADD_VAL, $random(seed));
      for (int i = 0; i < NCH; i++) begin
        write_reg(ADR_SET_VAL + 4 * i, $random(seed));
      end
      read_check(ADR_CTRL, "CTRL");
      read_check(ADR_CONV_MASK, "CONV_MASK");
      read_check(ADR_ADD_VAL, "ADD_VAL");
      for (int i = 0; i < NCH; i++) begin
        read_check(ADR_SET_VAL + 4 * i, $sformatf("SET_VAL%0d", i));
      end
    end
    read_check(ADR_CMD, "CMD");
    read_check('h1C, "unmapped 0x1C");
    adr = 'hC0 | (AW'($random(seed)) & 'h3F);
    read_check(adr, "unmapped high");
    test_done("register readback");
  endtask

  task automatic passthrough_bursts();
    write_reg(ADR_CONV_MASK, 32'h0);
    write_reg(ADR_ADD_VAL, $random(seed));
    write_reg(ADR_CTRL, 32'h1);
    write_reg(ADR_CMD, CMD_START);
    read_check(ADR_STATUS, "STATUS running");
    stream(60, 30);
    test_done("passthrough");
  endtask

  task automatic hole_insertion();
    write_reg(ADR_ADD_VAL, $random(seed));
    write_reg(ADR_CONV_MASK, $random(seed) | 1);
    stream(80, 0);
    stream(40, 30);
    test_done("hole insertion");
  endtask

  // Top bits of each preset differ, so the channels wrap at shifted beats
  task automatic preset_shift();
    for (int i = 0; i < NCH; i++) begin
      write_reg(ADR_SET_VAL + 4 * i, (32'(i) << 30) | ($random(seed) & 32'h00FF_FFFF));
    end
    write_reg(ADR_ADD_VAL, 32'h2000_0000 | ($random(seed) & 32'h00FF_FFFF));
    write_reg(ADR_CONV_MASK, (1 << NCH) - 1);
    write_reg(ADR_CMD, CMD_ACCUM_SET);
    stream(40, 0);
    test_done("preset shift");
  endtask

  task automatic run_control();
    sample_vec_t held;
    int          c;
    write_reg(ADR_CMD, CMD_STOP);
    read_check(ADR_STATUS, "STATUS after stop");
    stream(10, 0);
    write_reg(ADR_CTRL, 32'h0);
    write_reg(ADR_CMD, CMD_START);
    read_check(ADR_STATUS, "STATUS enable low");
    stream(10, 0);
    write_reg(ADR_CTRL, 32'h1);
    pulse_ext_start();
    read_check(ADR_STATUS, "STATUS trigger disarmed");
    stream(10, 0);
    write_reg(ADR_CTRL, 32'h3);
    pulse_ext_start();
    read_check(ADR_STATUS, "STATUS trigger armed");
    stream(20, 20);
    // The beat stays valid during the stop write, three edges accept it
    held = random_beat();
    drive_beat(1'b1, held);
    c = cycle;
    queue_expected_beat(held, c + 4);
    queue_expected_beat(held, c + 5);
    write_reg(ADR_CMD, CMD_STOP);
    repeat (6) drive_beat(1'b1, random_beat());
    drive_beat(1'b0, '0);
    wait_drain();
    read_check(ADR_STATUS, "STATUS after late stop");
    test_done("run control");
  endtask

  initial begin
    arst_n    <= 1'b0;
    wb_cyc    <= 1'b0;
    wb_stb    <= 1'b0;
    wb_we     <= 1'b0;
    wb_adr    <= '0;
    wb_dat_w  <= '0;
    ext_start <= 1'b0;
    in_valid  <= 1'b0;
    in_data   <= '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    registers_readback();
    passthrough_bursts();
    hole_insertion();
    preset_shift();
    run_control();
    if (fsrc_tx_top_inst.checker_inst.fail_count != 0) begin
      errors += fsrc_tx_top_inst.checker_inst.fail_count;
      $display("ERROR: %0d assertion failures in the bound checker",
               fsrc_tx_top_inst.checker_inst.fail_count);
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("ERROR: watchdog expired at %0t before the tests finished", $time);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/fsrc_pkg.sv
logic/fsrc_valid_stage.sv
logic/fsrc_phase_accum.sv
logic/fsrc_rate_core.sv
logic/fsrc_wb_regmap.sv
logic/fsrc_tx_top.sv
verif/fsrc_tx_checker.sv
verif/fsrc_tx_tb.sv
